/* hdl/bus_pkg.sv */
// ----------------------------------------------------------------------
// cpu side bus types for the read cache
// access size encoding, data word, request and response structs
// ----------------------------------------------------------------------
package bus_pkg;

    // encoding follows the load/store unit
    typedef enum logic [1:0] {
        SIZE_WORD = 2'b00,
        SIZE_BYTE = 2'b01,
        SIZE_HALF = 2'b10
    } access_size_t;

    typedef logic [31:0] data_t; // one bus word

    // request as presented with rd_req or wr_req
    typedef struct packed {
        logic [31:0]  addr;  // byte address, only low bits decoded
        access_size_t size;
        data_t        wdata; // store data, lane 0 aligned
    } cpu_req_t;

    // read response, qualified by rsp_valid
    typedef struct packed {
        data_t rdata; // zero extended
        logic  miss;  // response came through a line fill
    } cpu_rsp_t;

endpackage

/* hdl/cache_pkg.sv */
// ----------------------------------------------------------------------
// cache geometry and internal types
// line layout, fill state encoding and byte lane enables
// ----------------------------------------------------------------------
package cache_pkg;

    import bus_pkg::*;

    localparam int WORDS_PER_LINE = 4;
    localparam int OFFSET_BITS    = 2; // word within line
    localparam int BYTE_BITS      = 2; // byte within word

    // word 0 sits in the low bits of the line
    typedef data_t [WORDS_PER_LINE-1:0] line_data_t;

    // miss handling states
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_FILL    = 2'd1, // one ram word per clock
        ST_RESPOND = 2'd2  // line written, send response
    } fill_state_t;

    typedef logic [3:0] byte_en_t; // one bit per byte lane

endpackage

/* hdl/mem_array.sv */
// ----------------------------------------------------------------------
// generic storage array, payload type set per instance
// asynchronous read port, synchronous write port
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module mem_array #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 16
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  entry_t                   wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output entry_t                   rdata
);

    entry_t mem [DEPTH]; // contents undefined until written

    // write lands on the clock edge
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read is combinational, so a write shows up the cycle after the edge
    assign rdata = mem[raddr];

endmodule

/* hdl/beat_counter.sv */
// ----------------------------------------------------------------------
// beat counter for line fills
// counts word beats and flags the final beat of a line
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module beat_counter
    import cache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,   // new fill, back to beat 0
    input  logic                   advance, // one beat done
    output logic [OFFSET_BITS-1:0] beat,
    output logic                   last
);

    always_ff @(posedge clk) begin
        if (rst) begin
            beat <= '0;
        end else if (start) begin
            beat <= '0;
        end else if (advance) begin
            beat <= beat + 1'b1; // wraps to 0 after the last beat
        end
    end

    // final word of the line
    assign last = (beat == OFFSET_BITS'(WORDS_PER_LINE - 1));

endmodule

/* hdl/line_fill_fsm.sv */
// ----------------------------------------------------------------------
// line fill state machine
// fetches the four words of a missed line one per clock,
// writes line and tag on the last beat, then pulses the response
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module line_fill_fsm
    import bus_pkg::*;
    import cache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   miss_start,  // accepted read that missed
    input  data_t                  ram_word,    // ram word at fill address
    input  logic [OFFSET_BITS-1:0] beat,
    input  logic                   last,
    input  cpu_req_t               req_latched, // read that caused the miss
    output logic                   advance,
    output logic                   fill_we,     // line and tag write strobe
    output line_data_t             fill_line,
    output logic [OFFSET_BITS-1:0] fill_offset, // word of the line on this beat
    output logic                   busy,
    output logic                   rsp_valid,
    output logic                   rsp_from_miss
);

    fill_state_t            state;
    line_data_t             line_q;   // words gathered so far
    logic [OFFSET_BITS-1:0] crit_off; // word that missed
    logic                   resp_q;

    assign crit_off = req_latched.addr[BYTE_BITS +: OFFSET_BITS];

    // missed word first, the rest follow in wrap order
    assign fill_offset = crit_off + beat;

    assign advance = (state == ST_FILL);
    assign fill_we = (state == ST_FILL) && last; // line complete this cycle
    assign busy    = (state != ST_IDLE);

    // the beat word goes straight into the line so the write at the last
    // beat already carries all four words
    always_comb begin
        fill_line = line_q;
        if (state == ST_FILL) begin
            fill_line[fill_offset] = ram_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            resp_q <= 1'b0;
        end else begin
            resp_q <= (state == ST_RESPOND); // single cycle pulse
            case (state)
                ST_IDLE: begin
                    if (miss_start) begin
                        state <= ST_FILL;
                    end
                end
                ST_FILL: begin
                    if (last) begin
                        state <= ST_RESPOND;
                    end
                end
                ST_RESPOND: state <= ST_IDLE; // busy drops as the pulse rises
                default:    state <= ST_IDLE;
            endcase
        end
    end

    // line register holds its words until the next fill starts
    always_ff @(posedge clk) begin
        if (state == ST_FILL) begin
            line_q[fill_offset] <= ram_word;
        end
    end

    assign rsp_valid     = resp_q;
    assign rsp_from_miss = resp_q; // this pulse only ever answers a miss

endmodule

/* hdl/load_align.sv */
// ----------------------------------------------------------------------
// load alignment
// picks the byte or halfword lane and zero extends it
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module load_align
    import bus_pkg::*;
(
    input  data_t        word,     // selected cache or line word
    input  logic [1:0]   byte_sel, // byte offset in the word
    input  access_size_t size,
    output data_t        rdata
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // byte lane from the full offset
    assign byte_lane = word[8*byte_sel +: 8];

    // halfwords are even aligned, bit 1 picks upper or lower
    assign half_lane = word[16*byte_sel[1] +: 16];

    always_comb begin
        case (size)
            SIZE_BYTE: begin
                rdata = {24'b0, byte_lane};
            end
            SIZE_HALF: begin
                rdata = {16'b0, half_lane};
            end
            default: begin
                rdata = word; // full word, offset ignored
            end
        endcase
    end

endmodule

/* hdl/store_merge.sv */
// ----------------------------------------------------------------------
// store merge
// builds byte enables and merges store data into the ram word
// and into the addressed word of a cached line
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module store_merge
    import bus_pkg::*;
    import cache_pkg::*;
(
    input  data_t      old_word,   // current ram word
    input  line_data_t old_line,   // current cached line of the set
    input  cpu_req_t   req,
    output data_t      ram_wdata,
    output line_data_t line_wdata
);

    byte_en_t               be;
    data_t                  wdata_rep; // store data copied onto every lane
    data_t                  line_word;
    logic [BYTE_BITS-1:0]   byte_sel;
    logic [OFFSET_BITS-1:0] word_sel;

    assign byte_sel = req.addr[BYTE_BITS-1:0];
    assign word_sel = req.addr[BYTE_BITS +: OFFSET_BITS];

    always_comb begin
        case (req.size)
            SIZE_BYTE: begin
                be        = byte_en_t'(4'b0001 << byte_sel);
                wdata_rep = {4{req.wdata[7:0]}};
            end
            SIZE_HALF: begin
                be        = byte_en_t'(4'b0011 << byte_sel); // even offsets only
                wdata_rep = {2{req.wdata[15:0]}};
            end
            default: begin
                be        = 4'b1111;
                wdata_rep = req.wdata;
            end
        endcase
    end

    // only enabled lanes change
    always_comb begin
        ram_wdata = old_word;
        line_word = old_line[word_sel];
        for (int i = 0; i < $bits(byte_en_t); i++) begin
            if (be[i]) begin
                ram_wdata[8*i +: 8] = wdata_rep[8*i +: 8];
                line_word[8*i +: 8] = wdata_rep[8*i +: 8];
            end
        end
        line_wdata           = old_line;
        line_wdata[word_sel] = line_word;
    end

endmodule

/* hdl/cache_top.sv */
// ----------------------------------------------------------------------
// direct mapped read cache with write through stores
// address decode, hit check, response path and block instances
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module cache_top
    import bus_pkg::*;
    import cache_pkg::*;
#(
    parameter int ADDR_WIDTH = 12, // byte address bits decoded
    parameter int SET_BITS   = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     rd_req,
    input  logic     wr_req,
    input  cpu_req_t req,
    output logic     rsp_valid,
    output cpu_rsp_t rsp,
    output logic     busy
);

    localparam int TAG_BITS   = ADDR_WIDTH - SET_BITS - OFFSET_BITS - BYTE_BITS;
    localparam int WADDR_BITS = ADDR_WIDTH - BYTE_BITS; // ram word index
    localparam int SETS       = 1 << SET_BITS;

    typedef struct packed {
        logic                valid;
        logic [TAG_BITS-1:0] tag;
    } tag_entry_t;

    logic [TAG_BITS-1:0]    req_tag, lat_tag;
    logic [SET_BITS-1:0]    req_set, lat_set;
    logic [OFFSET_BITS-1:0] req_off, fill_offset, beat;
    logic [BYTE_BITS-1:0]   req_byte;
    logic [WADDR_BITS-1:0]  ram_raddr;
    cpu_req_t               req_latched;
    tag_entry_t             tag_rd, tag_wr;
    logic [SETS-1:0]        valid_vec; // cleared on reset, set by fills
    line_data_t             line_rd, line_wr, line_wdata, fill_line;
    data_t                  ram_rd, ram_wdata, align_word, aligned;
    data_t                  hit_rdata_q, hit_rsp_rdata, miss_rdata_q;
    logic [BYTE_BITS-1:0]   align_byte;
    access_size_t           align_size;
    logic accept_rd, accept_wr, hit, line_we, fill_we, advance, last;
    logic fsm_rsp_valid, rsp_from_miss, hit_pend, hit_rsp_valid;

    assign {req_tag, req_set, req_off, req_byte} = req.addr[ADDR_WIDTH-1:0];
    assign {lat_tag, lat_set} = req_latched.addr[ADDR_WIDTH-1 -: TAG_BITS + SET_BITS];

    assign accept_rd = rd_req && !busy; // strobes during a fill are dropped
    assign accept_wr = wr_req && !busy;

    assign hit = valid_vec[req_set] && tag_rd.valid && (tag_rd.tag == req_tag);

    // line store takes fills, or store data on a store hit
    assign line_we = fill_we || (accept_wr && hit);
    assign line_wr = fill_we ? fill_line : line_wdata;
    assign tag_wr  = '{valid: 1'b1, tag: lat_tag};

    // fill beats own the ram read port while busy
    assign ram_raddr = busy ? {lat_tag, lat_set, fill_offset} : {req_tag, req_set, req_off};

    mem_array #(.entry_t(data_t), .DEPTH(1 << WADDR_BITS)) ram (
        .clk, .we(accept_wr), .waddr({req_tag, req_set, req_off}), .wdata(ram_wdata),
        .raddr(ram_raddr), .rdata(ram_rd)
    );

    mem_array #(.entry_t(line_data_t), .DEPTH(SETS)) line_store (
        .clk, .we(line_we), .waddr(fill_we ? lat_set : req_set), .wdata(line_wr),
        .raddr(req_set), .rdata(line_rd)
    );

    mem_array #(.entry_t(tag_entry_t), .DEPTH(SETS)) tag_store (
        .clk, .we(fill_we), .waddr(lat_set), .wdata(tag_wr),
        .raddr(req_set), .rdata(tag_rd)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_vec <= '0; // whole vector in one cycle
        end else if (fill_we) begin
            valid_vec[lat_set] <= 1'b1;
        end
    end

    beat_counter u_beat (
        .clk, .rst, .start(accept_rd && !hit), .advance, .beat, .last
    );

    line_fill_fsm u_fsm (
        .clk, .rst, .miss_start(accept_rd && !hit), .ram_word(ram_rd), .beat, .last,
        .req_latched, .advance, .fill_we, .fill_line, .fill_offset, .busy,
        .rsp_valid(fsm_rsp_valid), .rsp_from_miss
    );

    store_merge u_merge (
        .old_word(ram_rd), .old_line(line_rd), .req, .ram_wdata, .line_wdata
    );

    // miss data is aligned while busy, so the response cycle is free for a new hit
    always_comb begin
        if (busy) begin
            align_word = fill_line[req_latched.addr[BYTE_BITS +: OFFSET_BITS]];
            align_byte = req_latched.addr[BYTE_BITS-1:0];
            align_size = req_latched.size;
        end else begin
            align_word = line_rd[req_off]; // hit path, current request
            align_byte = req_byte;
            align_size = req.size;
        end
    end

    load_align u_align (
        .word(align_word), .byte_sel(align_byte), .size(align_size), .rdata(aligned)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            hit_pend      <= 1'b0;
            hit_rsp_valid <= 1'b0;
        end else begin
            hit_pend      <= accept_rd && hit;
            hit_rsp_valid <= hit_pend; // one cycle behind the data
        end
    end

    always_ff @(posedge clk) begin
        if (accept_rd) begin
            req_latched <= req;
            hit_rdata_q <= aligned;
        end
        if (busy) begin
            miss_rdata_q <= aligned; // last update lands as the respond state ends
        end
        hit_rsp_rdata <= hit_rdata_q; // second stage keeps back to back hits apart
    end

    assign rsp_valid = hit_rsp_valid || fsm_rsp_valid;
    assign rsp.rdata = rsp_from_miss ? miss_rdata_q : hit_rsp_rdata;
    assign rsp.miss  = rsp_from_miss;

endmodule

/* verif/cache_assertions.sv */
// ----------------------------------------------------------------------
// response and fill timing assertions, bound into cache_top
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module cache_assertions (
    input logic clk,
    input logic rst,
    input logic rsp_valid,
    input logic busy
);

    // every response is a single cycle pulse
    property rsp_single_pulse;
        @(posedge clk) disable iff (rst) rsp_valid |=> !rsp_valid;
    endproperty

    assert property (rsp_single_pulse)
        else $error("rsp_valid held high for two cycles");

    // nothing in flight straight out of reset
    assert property (@(posedge clk) rst |=> !busy)
        else $error("busy high in the cycle after reset");

    // four beats, one respond cycle, then the pulse as busy drops
    property miss_latency;
        @(posedge clk) disable iff (rst)
            $rose(busy) |-> ##4 (busy && !rsp_valid) ##1 (rsp_valid && !busy);
    endproperty

    assert property (miss_latency)
        else $error("miss response not five cycles after busy rose");

endmodule

bind cache_top cache_assertions u_assertions (
    .clk, .rst, .rsp_valid, .busy
);

/* verif/cache_tb.sv */
// ----------------------------------------------------------------------
// testbench for the read cache with clock, reset, shadow byte memory
// and shadow tag model, operations read from the tests file
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module cache_tb
    import bus_pkg::*;
();

    localparam int ADDR_WIDTH  = 12;
    localparam int SET_BITS    = 4;
    localparam int LINE_SHIFT  = 4;  // byte and word offset bits
    localparam int RSP_TIMEOUT = 20; // cycles allowed for a read response

    logic        clk, rst, rd_req, wr_req, rsp_valid, busy;
    cpu_req_t    req;
    cpu_rsp_t    rsp;
    logic [7:0]  shadow_mem [1 << ADDR_WIDTH]; // byte image of the ram
    logic        shadow_valid [1 << SET_BITS];
    int          shadow_tag [1 << SET_BITS];
    int          fd, status, tests_run, tests_failed, errors, test_errors;
    string       line_str, name, op, size_str;
    logic [31:0] addr, wdata, exp_rdata;
    int          exp_miss;

    cache_top #(.ADDR_WIDTH(ADDR_WIDTH), .SET_BITS(SET_BITS)) uut (
        .clk, .rst, .rd_req, .wr_req, .req, .rsp_valid, .rsp, .busy
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int size_bytes(input access_size_t sz);
        case (sz)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            default:   return 4;
        endcase
    endfunction

    function automatic access_size_t decode_size(input string s);
        if (s == "B") return SIZE_BYTE;
        if (s == "H") return SIZE_HALF;
        return SIZE_WORD;
    endfunction

    // little endian lanes, upper bytes stay zero
    function automatic data_t shadow_read(input int a, input int nbytes);
        data_t                 v;
        logic [ADDR_WIDTH-1:0] idx;
        v = '0;
        for (int i = 0; i < nbytes; i++) begin
            idx         = ADDR_WIDTH'(a + i);
            v[8*i +: 8] = shadow_mem[idx];
        end
        return v;
    endfunction

    function automatic void shadow_write(input int a, input int nbytes, input data_t wd);
        logic [ADDR_WIDTH-1:0] idx;
        for (int i = 0; i < nbytes; i++) begin
            idx             = ADDR_WIDTH'(a + i);
            shadow_mem[idx] = wd[8*i +: 8];
        end
    endfunction

    // direct mapped lookup, a read always leaves its line in the set
    function automatic logic tag_lookup_fill(input int a);
        logic [SET_BITS-1:0] set_idx;
        int                  tag;
        logic                miss;
        set_idx = SET_BITS'(a >> LINE_SHIFT);
        tag     = a >> (LINE_SHIFT + SET_BITS);
        miss    = !(shadow_valid[set_idx] && shadow_tag[set_idx] == tag);
        shadow_valid[set_idx] = 1'b1;
        shadow_tag[set_idx]   = tag;
        return miss;
    endfunction

    // one cycle strobe, driven just after the edge
    task automatic send_request(input logic is_read, input logic [31:0] a,
                                input access_size_t sz, input data_t wd);
        @(posedge clk);
        #1;
        rd_req    = is_read;
        wr_req    = !is_read;
        req.addr  = a;
        req.size  = sz;
        req.wdata = wd;
        @(posedge clk);
        #1;
        rd_req = 1'b0;
        wr_req = 1'b0;
    endtask

    task automatic wait_response(output logic got, output data_t rdata, output logic miss);
        int cycles;
        got    = 1'b0;
        rdata  = '0;
        miss   = 1'b0;
        cycles = 0;
        while (!got && cycles < RSP_TIMEOUT) begin
            @(negedge clk); // outputs settled mid cycle
            cycles++;
            if (rsp_valid) begin
                got   = 1'b1;
                rdata = rsp.rdata;
                miss  = rsp.miss;
            end
        end
    endtask

    task automatic wait_busy(output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < 5) begin
            @(negedge clk);
            cycles++;
            seen = busy;
        end
    endtask

    task automatic count_responses(input int window, output int count);
        count = 0;
        repeat (window) begin
            @(negedge clk);
            if (rsp_valid) count++;
        end
    endtask

    task automatic run_operation();
        access_size_t sz;
        int           a, extra;
        data_t        model_rdata, act_rdata;
        logic         model_miss, act_miss, got, seen;
        test_errors = 0;
        sz = decode_size(size_str);
        a  = int'(addr[ADDR_WIDTH-1:0]);
        if (op == "W") begin
            send_request(1'b0, addr, sz, wdata);
            @(posedge clk); // write through, no response
            shadow_write(a, size_bytes(sz), wdata);
        end else if (op == "R" || op == "B") begin
            model_rdata = shadow_read(a, size_bytes(sz));
            model_miss  = tag_lookup_fill(a);
            if (model_rdata != exp_rdata) begin
                $display("Mismatch %s model rdata: expected %h, actual %h",
                         name, exp_rdata, model_rdata);
                test_errors++;
            end
            if (model_miss != (exp_miss != 0)) begin
                $display("Mismatch %s model miss: expected %0d, actual %0d",
                         name, exp_miss, model_miss);
                test_errors++;
            end
            send_request(1'b1, addr, sz, '0);
            if (op == "B") begin
                wait_busy(seen);
                if (!seen) begin
                    $display("%s: busy did not rise after a read miss", name);
                    test_errors++;
                end
                send_request(1'b1, wdata, SIZE_WORD, '0); // stray read, must be dropped
            end
            wait_response(got, act_rdata, act_miss);
            if (!got) begin
                $display("%s: no response within %0d cycles", name, RSP_TIMEOUT);
                test_errors++;
            end else begin
                if (act_rdata != exp_rdata) begin
                    $display("Mismatch %s rdata: expected %h, actual %h",
                             name, exp_rdata, act_rdata);
                    test_errors++;
                end
                if (act_miss != (exp_miss != 0)) begin
                    $display("Mismatch %s miss: expected %0d, actual %0d",
                             name, exp_miss, act_miss);
                    test_errors++;
                end
            end
            count_responses(10, extra);
            if (extra != 0) begin
                $display("%s: %0d extra responses after the read", name, extra);
                test_errors++;
            end
        end else begin
            $display("%s: unknown operation %s", name, op);
            test_errors++;
        end
        tests_run++;
        errors += test_errors;
        if (test_errors != 0) tests_failed++;
        $display("test %s: %s", name, (test_errors == 0) ? "ok" : "failed");
    endtask

    initial begin
        rst          = 1'b1;
        rd_req       = 1'b0;
        wr_req       = 1'b0;
        req          = '0;
        shadow_valid = '{default: 1'b0};
        shadow_tag   = '{default: 0};
        tests_run    = 0;
        tests_failed = 0;
        errors       = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        fd  = $fopen("verif/cache_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/cache_tests.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line_str = "";
                status   = $fgets(line_str, fd);
                if (line_str.len() > 1 && line_str[0] != "#") begin // skip comments
                    status = $sscanf(line_str, "%s %s %h %s %h %h %d", name, op, addr,
                                     size_str, wdata, exp_rdata, exp_miss);
                    if (status == 7) begin
                        run_operation();
                    end else begin
                        $display("malformed line in tests file: %s", line_str);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
        $display("tests run %0d, failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0 && tests_run > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verif/cache_tests.txt */
# columns: name op addr size wdata exp_rdata exp_miss, all hex except exp_miss
# op W store, R read, B read with a stray read of address wdata issued while busy
w0         W 100 W 11223344 0 0
w1         W 104 W 55667788 0 0
w2         W 108 W 99aabbcc 0 0
w3         W 10c W ddeeff00 0 0
cold_rd    R 104 W 0 55667788 1
fill_rd0   R 100 W 0 11223344 0
fill_rd2   R 108 W 0 99aabbcc 0
fill_rd3   R 10c W 0 ddeeff00 0
hit_b0     R 108 B 0 000000cc 0
hit_b1     R 109 B 0 000000bb 0
hit_b2     R 10a B 0 000000aa 0
hit_b3     R 10b B 0 00000099 0
hit_h0     R 10c H 0 0000ff00 0
hit_h2     R 10e H 0 0000ddee 0
w_234      W 234 W 0badf00d 0 0
w_238      W 238 W 12345678 0 0
miss_b2    R 23a B 0 00000034 1
hit_h2b    R 236 H 0 00000bad 0
st_hit     W 109 B 5a 0 0
st_hit_rd  R 108 W 0 99aa5acc 0
st_miss_w  W 350 W 0f0e0d0c 0 0
st_miss_b  W 351 B 77 0 0
st_miss_rd R 350 W 0 0f0e770c 1
conf_w     W 404 W 4444aaaa 0 0
conf_rd0   R 404 H 0 0000aaaa 1
conf_rd1   R 104 W 0 55667788 1
conf_rd2   R 406 H 0 00004444 1
busy_rd    B 100 W 10c 11223344 1
busy_next  R 404 W 0 4444aaaa 1

/* tb.f */
hdl/bus_pkg.sv
hdl/cache_pkg.sv
hdl/mem_array.sv
hdl/beat_counter.sv
hdl/line_fill_fsm.sv
hdl/load_align.sv
hdl/store_merge.sv
hdl/cache_top.sv
verif/cache_assertions.sv
verif/cache_tb.sv

/* run.sh */
#!/bin/sh
# build the cache testbench with verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module cache_tb -f tb.f \
    && ./obj_dir/Vcache_tb 2>&1 | tee sim.log \
    || { echo "build or simulation failed"; exit 1; }

grep -q "ALL TESTS PASSED" sim.log \
    && echo "result: pass" \
    || { echo "result: fail"; exit 1; }
